// ==== Makefile ====
# Verilator build and run of the byte crossbar testbench
VERILATOR = verilator
VFLAGS    = --binary --timing -j 0
TOP       = tb_byte_xbar
FILELIST  = files.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

# the log is searched for the pass line, grep sets the exit status
run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "ALL CHECKS PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== common/lane_if.sv ====
// one crossbar lane's configuration and result, shared by the write port, the lane and the read port
`timescale 1ns/1ps
`include "xbar_macros.svh"

interface lane_if;

    // source array, identical copy in every lane
    xbar_pkg::byte_t ary [`XBAR_WIDTH-1:0];
    // lane select and its written flag
    xbar_pkg::sel_t  sel;
    logic            sel_vld;
    // registered lane output
    xbar_pkg::byte_t dat;
    logic            dat_vld;

    // register block side
    modport wr (output ary, sel, sel_vld);
    // the lane itself
    modport ln (input ary, sel, sel_vld, output dat, dat_vld);
    // readback side
    modport rd (input dat, dat_vld);

endinterface

// ==== common/xbar_macros.svh ====
// crossbar sizes and register map bases, included by the package and every RTL file that needs them
`ifndef XBAR_MACROS_SVH
`define XBAR_MACROS_SVH

// number of source bytes, not a power of the split on purpose
`define XBAR_WIDTH 12
// fan-in of each mux tree node
`define XBAR_SPLIT 2
// number of crossbar output lanes
`define XBAR_LANES 4

// AXI4-Lite address width
`define XBAR_ADDR_W 8

// source byte i at base + 4i, low 8 bits
`define XBAR_SRC_BASE 8'h00
// lane k select at base + 4k
`define XBAR_SEL_BASE 8'h40
// lane k output at base + 4k, read only
`define XBAR_OUT_BASE 8'h80

`endif

// ==== common/xbar_pkg.sv ====
// shared crossbar types, referenced by scoped names from the interface and the RTL modules
`include "xbar_macros.svh"

package xbar_pkg;

    ////////////////////////////////////////////////////////////
    // data types
    ////////////////////////////////////////////////////////////

    // one data byte, element type of every mux
    typedef logic [7:0] byte_t;

    // binary select of one source byte
    typedef logic [$clog2(`XBAR_WIDTH)-1:0] sel_t;

    ////////////////////////////////////////////////////////////
    // encodings
    ////////////////////////////////////////////////////////////

    // AXI response codes, only the two in use
    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        SLVERR = 2'b10
    } resp_e;

    // write channel FSM
    typedef enum logic {WR_IDLE, WR_RESP} wr_state_e;

    // read channel FSM
    typedef enum logic {RD_IDLE, RD_RESP} rd_state_e;

endpackage

// ==== design/byte_xbar_top.sv ====
// byte crossbar top level with plain AXI4-Lite ports, wires the write port, lanes and read port
`timescale 1ns/1ps
`include "xbar_macros.svh"

module byte_xbar_top (
    input  logic                     clk,
    input  logic                     arst_n,
    // write address
    input  logic [`XBAR_ADDR_W-1:0]  awaddr,
    input  logic                     awvalid,
    output logic                     awready,
    // write data
    input  logic [31:0]              wdata,
    input  logic [3:0]               wstrb,
    input  logic                     wvalid,
    output logic                     wready,
    // write response
    output logic [1:0]               bresp,
    output logic                     bvalid,
    input  logic                     bready,
    // read address
    input  logic [`XBAR_ADDR_W-1:0]  araddr,
    input  logic                     arvalid,
    output logic                     arready,
    // read data
    output logic [31:0]              rdata,
    output logic [1:0]               rresp,
    output logic                     rvalid,
    input  logic                     rready
);

    // one interface per lane
    lane_if lane_bus [`XBAR_LANES-1:0] ();

    // stored registers tapped for readback
    xbar_pkg::byte_t src_ary [`XBAR_WIDTH-1:0];
    xbar_pkg::sel_t  sel_ary [`XBAR_LANES-1:0];

    ////////////////////////////////////////////////////////////
    // register write side
    ////////////////////////////////////////////////////////////

    xbar_write_port i_write_port (
        .clk     (clk),
        .arst_n  (arst_n),
        .awaddr  (awaddr),
        .awvalid (awvalid),
        .awready (awready),
        .wdata   (wdata),
        .wstrb   (wstrb),
        .wvalid  (wvalid),
        .wready  (wready),
        .bresp   (bresp),
        .bvalid  (bvalid),
        .bready  (bready),
        .lanes   (lane_bus)
    );

    // source array is the same in every lane, take lane 0
    assign src_ary = lane_bus[0].ary;

    ////////////////////////////////////////////////////////////
    // crossbar lanes
    ////////////////////////////////////////////////////////////

    for (genvar k = 0; k < `XBAR_LANES; k++) begin: g_lane
        xbar_lane i_lane (
            .clk    (clk),
            .arst_n (arst_n),
            .lane   (lane_bus[k])
        );
        assign sel_ary[k] = lane_bus[k].sel;
    end

    ////////////////////////////////////////////////////////////
    // readback side
    ////////////////////////////////////////////////////////////

    xbar_read_port i_read_port (
        .clk     (clk),
        .arst_n  (arst_n),
        .araddr  (araddr),
        .arvalid (arvalid),
        .arready (arready),
        .rdata   (rdata),
        .rresp   (rresp),
        .rvalid  (rvalid),
        .rready  (rready),
        .lanes   (lane_bus),
        .src_ary (src_ary),
        .sel_ary (sel_ary)
    );

endmodule

// ==== design/xbar_lane.sv ====
// one crossbar lane, picks a source byte by its select and registers it with a valid flag
`timescale 1ns/1ps
`include "xbar_macros.svh"

module xbar_lane (
    input  logic clk,
    input  logic arst_n,
    // configuration in, result out
    lane_if.ln   lane
);

    // combinational pick, before the register
    xbar_pkg::byte_t pick;

    // 12 inputs, so the padded path of the mux is in use
    mux_bin #(
        .DAT_T (xbar_pkg::byte_t),
        .WIDTH (`XBAR_WIDTH),
        .SPLIT (`XBAR_SPLIT)
    ) i_mux (
        .bin (lane.sel),
        .ary (lane.ary),
        .dat (pick)
    );

    // valid follows the select flag one cycle later
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            lane.dat_vld <= 1'b0;
        end else begin
            lane.dat_vld <= lane.sel_vld;
        end
    end

    // byte reloaded every edge, so config changes show up next cycle
    always_ff @(posedge clk) begin
        lane.dat <= pick;
    end

endmodule

// ==== design/xbar_read_port.sv ====
// AXI4-Lite read channel, answers from the source bytes, the selects or a lane output
`timescale 1ns/1ps
`include "xbar_macros.svh"

module xbar_read_port (
    input  logic                     clk,
    input  logic                     arst_n,
    // AR channel
    input  logic [`XBAR_ADDR_W-1:0]  araddr,
    input  logic                     arvalid,
    output logic                     arready,
    // R channel
    output logic [31:0]              rdata,
    output xbar_pkg::resp_e          rresp,
    output logic                     rvalid,
    input  logic                     rready,
    // lane results and stored registers for readback
    lane_if.rd                       lanes [`XBAR_LANES-1:0],
    input  xbar_pkg::byte_t          src_ary [`XBAR_WIDTH-1:0],
    input  xbar_pkg::sel_t           sel_ary [`XBAR_LANES-1:0]
);

    localparam logic [`XBAR_ADDR_W-1:0] SRC_SPAN = 4 * `XBAR_WIDTH;
    localparam logic [`XBAR_ADDR_W-1:0] LANE_SPAN = 4 * `XBAR_LANES;

    xbar_pkg::rd_state_e             state;
    xbar_pkg::rd_state_e             state_nxt;
    logic                            ar_hs;

    logic [`XBAR_ADDR_W-1:0]         src_off;
    logic [`XBAR_ADDR_W-1:0]         sel_off;
    logic [`XBAR_ADDR_W-1:0]         out_off;
    logic [$clog2(`XBAR_WIDTH)-1:0]  src_idx;
    logic [$clog2(`XBAR_LANES)-1:0]  sel_idx;
    logic [$clog2(`XBAR_LANES)-1:0]  out_idx;

    xbar_pkg::byte_t                 lane_dat [`XBAR_LANES-1:0];
    logic [`XBAR_LANES-1:0]          lane_vld;
    xbar_pkg::byte_t                 lane_pick;
    logic [31:0]                     rd_dat;
    xbar_pkg::resp_e                 rd_resp;

    ////////////////////////////////////////////////////////////
    // FSM
    ////////////////////////////////////////////////////////////

    assign ar_hs = arvalid && arready;

    always_comb begin
        state_nxt = state;
        case (state)
            xbar_pkg::RD_IDLE: if (ar_hs)  state_nxt = xbar_pkg::RD_RESP;
            xbar_pkg::RD_RESP: if (rready) state_nxt = xbar_pkg::RD_IDLE;
            default:                       state_nxt = xbar_pkg::RD_IDLE;
        endcase
    end

    // arready registered, low through reset and high in idle
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state   <= xbar_pkg::RD_IDLE;
            arready <= 1'b0;
        end else begin
            state   <= state_nxt;
            arready <= (state_nxt == xbar_pkg::RD_IDLE);
        end
    end

    assign rvalid = (state == xbar_pkg::RD_RESP);

    ////////////////////////////////////////////////////////////
    // decode and lane pick
    ////////////////////////////////////////////////////////////

    // wrapped offsets, same scheme as the write side
    assign src_off = araddr - `XBAR_SRC_BASE;
    assign sel_off = araddr - `XBAR_SEL_BASE;
    assign out_off = araddr - `XBAR_OUT_BASE;
    assign src_idx = src_off[2 +: $clog2(`XBAR_WIDTH)];
    assign sel_idx = sel_off[2 +: $clog2(`XBAR_LANES)];
    assign out_idx = out_off[2 +: $clog2(`XBAR_LANES)];

    // flatten the lane interfaces
    for (genvar k = 0; k < `XBAR_LANES; k++) begin: g_lane
        assign lane_dat[k] = lanes[k].dat;
        assign lane_vld[k] = lanes[k].dat_vld;
    end

    // lane byte picked by address bits
    mux_bin #(
        .DAT_T (xbar_pkg::byte_t),
        .WIDTH (`XBAR_LANES),
        .SPLIT (`XBAR_SPLIT)
    ) i_mux (
        .bin (out_idx),
        .ary (lane_dat),
        .dat (lane_pick)
    );

    // unmapped or invalid lane gives zero with SLVERR
    always_comb begin
        rd_dat  = '0;
        rd_resp = xbar_pkg::SLVERR;
        if (src_off < SRC_SPAN) begin
            rd_dat  = 32'(src_ary[src_idx]);
            rd_resp = xbar_pkg::OKAY;
        end else if (sel_off < LANE_SPAN) begin
            rd_dat  = 32'(sel_ary[sel_idx]);
            rd_resp = xbar_pkg::OKAY;
        end else if (out_off < LANE_SPAN && lane_vld[out_idx]) begin
            rd_dat  = 32'(lane_pick);
            rd_resp = xbar_pkg::OKAY;
        end
    end

    // payload captured on the AR handshake, held while rvalid
    always_ff @(posedge clk) begin
        if (ar_hs) begin
            rdata <= rd_dat;
            rresp <= rd_resp;
        end
    end

endmodule

// ==== design/xbar_write_port.sv ====
// AXI4-Lite write channel holding the source bytes and lane selects, drives every lane interface
`timescale 1ns/1ps
`include "xbar_macros.svh"

module xbar_write_port (
    input  logic                     clk,
    input  logic                     arst_n,
    // AW and W channels
    input  logic [`XBAR_ADDR_W-1:0]  awaddr,
    input  logic                     awvalid,
    output logic                     awready,
    input  logic [31:0]              wdata,
    input  logic [3:0]               wstrb,
    input  logic                     wvalid,
    output logic                     wready,
    // B channel
    output xbar_pkg::resp_e          bresp,
    output logic                     bvalid,
    input  logic                     bready,
    // configuration towards the lanes
    lane_if.wr                       lanes [`XBAR_LANES-1:0]
);

    // span of each region in bytes
    localparam logic [`XBAR_ADDR_W-1:0] SRC_SPAN = 4 * `XBAR_WIDTH;
    localparam logic [`XBAR_ADDR_W-1:0] SEL_SPAN = 4 * `XBAR_LANES;

    xbar_pkg::wr_state_e             state;
    xbar_pkg::byte_t                 src_q [`XBAR_WIDTH-1:0];
    xbar_pkg::sel_t                  sel_q [`XBAR_LANES-1:0];
    logic [`XBAR_LANES-1:0]          sel_vld_q;

    logic [`XBAR_ADDR_W-1:0]         src_off;
    logic [`XBAR_ADDR_W-1:0]         sel_off;
    logic [$clog2(`XBAR_WIDTH)-1:0]  src_idx;
    logic [$clog2(`XBAR_LANES)-1:0]  lane_idx;
    logic                            src_hit;
    logic                            sel_hit;
    logic                            strb_any;
    logic                            sel_bad;
    logic                            wr_hs;
    logic                            wr_err;

    ////////////////////////////////////////////////////////////
    // handshake and decode
    ////////////////////////////////////////////////////////////

    // address and data taken together, only when both are offered
    assign wr_hs   = (state == xbar_pkg::WR_IDLE) && awvalid && wvalid;
    assign awready = wr_hs;
    assign wready  = wr_hs;

    // offsets wrap below the base, so one compare covers both ends
    assign src_off  = awaddr - `XBAR_SRC_BASE;
    assign sel_off  = awaddr - `XBAR_SEL_BASE;
    assign src_hit  = src_off < SRC_SPAN;
    assign sel_hit  = sel_off < SEL_SPAN;
    assign src_idx  = src_off[2 +: $clog2(`XBAR_WIDTH)];
    assign lane_idx = sel_off[2 +: $clog2(`XBAR_LANES)];

    // strobes only matter as a whole
    assign strb_any = |wstrb;
    // select beyond the source array
    assign sel_bad  = wdata >= 32'(`XBAR_WIDTH);
    // output region is read only, so it falls out as unmapped
    assign wr_err   = !(src_hit || sel_hit) || (sel_hit && strb_any && sel_bad);

    ////////////////////////////////////////////////////////////
    // FSM and registers
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state     <= xbar_pkg::WR_IDLE;
            src_q     <= '{default: '0};
            sel_q     <= '{default: '0};
            sel_vld_q <= '0;
        end else begin
            case (state)
                xbar_pkg::WR_IDLE: if (wr_hs)  state <= xbar_pkg::WR_RESP;
                xbar_pkg::WR_RESP: if (bready) state <= xbar_pkg::WR_IDLE;
                default:                       state <= xbar_pkg::WR_IDLE;
            endcase
            // legal write with any strobe set
            if (wr_hs && strb_any && !wr_err) begin
                if (src_hit) begin
                    src_q[src_idx] <= wdata[7:0];
                end else begin
                    sel_q[lane_idx]     <= xbar_pkg::sel_t'(wdata);
                    sel_vld_q[lane_idx] <= 1'b1;
                end
            end
        end
    end

    // response captured on the acceptance edge
    always_ff @(posedge clk) begin
        if (wr_hs) begin
            bresp <= wr_err ? xbar_pkg::SLVERR : xbar_pkg::OKAY;
        end
    end

    // response held until bready
    assign bvalid = (state == xbar_pkg::WR_RESP);

    // every lane sees the whole source array and its own select
    for (genvar k = 0; k < `XBAR_LANES; k++) begin: g_drive
        assign lanes[k].ary     = src_q;
        assign lanes[k].sel     = sel_q[k];
        assign lanes[k].sel_vld = sel_vld_q[k];
    end

endmodule

// ==== files.f ====
+incdir+common
common/xbar_pkg.sv
common/lane_if.sv
mux/mux_bin_tree.sv
mux/mux_bin.sv
design/xbar_write_port.sv
design/xbar_lane.sv
design/xbar_read_port.sv
design/byte_xbar_top.sv
sim/tb_clock.sv
sim/tb_byte_xbar.sv

// ==== mux/mux_bin.sv ====
// binary select multiplexer, pads the width up to a power of the split and feeds the tree
`timescale 1ns/1ps

module mux_bin #(
    // element type
    parameter  type         DAT_T     = logic [8-1:0],
    // number of inputs and tree fan-in
    parameter  int unsigned WIDTH     = 32,
    parameter  int unsigned SPLIT     = 2,
    // select widths
    localparam int unsigned WIDTH_LOG = $clog2(WIDTH),
    localparam int unsigned SPLIT_LOG = $clog2(SPLIT)
)(
    // binary select
    input  logic [WIDTH_LOG-1:0] bin,
    // input array
    input  DAT_T                 ary [WIDTH-1:0],
    // selected element
    output DAT_T                 dat
);

    // tree levels, log of WIDTH in base SPLIT rounded up
    localparam int unsigned POWER_LOG = WIDTH_LOG/SPLIT_LOG + (WIDTH_LOG%SPLIT_LOG > 0 ? 1 : 0);
    // padded width seen by the tree
    localparam int unsigned POWER     = SPLIT**POWER_LOG;

    generate
    if (SPLIT != (2**SPLIT_LOG)) begin: validation

        // tree digits are bit fields, so the split must be a power of two
        $error("mux_bin: SPLIT is not a power of 2");

    end: validation
    else if (WIDTH != POWER) begin: extend

        logic [$clog2(POWER)-1:0] bin_pad;
        DAT_T                     ary_pad [POWER-1:0];

        // select widened with zeros
        assign bin_pad = ($clog2(POWER))'(bin);

        // upper entries tied to zero, never picked by a legal select
        always_comb begin
            for (int unsigned i = 0; i < POWER; i++) begin
                ary_pad[i] = (i < WIDTH) ? ary[i] : '0;
            end
        end

        mux_bin_tree #(
            .DAT_T (DAT_T),
            .WIDTH (POWER),
            .SPLIT (SPLIT)
        ) i_tree (
            .bin (bin_pad),
            .ary (ary_pad),
            .dat (dat)
        );

    end: extend
    else begin: exact

        // width already a power of the split
        mux_bin_tree #(
            .DAT_T (DAT_T),
            .WIDTH (WIDTH),
            .SPLIT (SPLIT)
        ) i_tree (
            .bin (bin),
            .ary (ary),
            .dat (dat)
        );

    end: exact
    endgenerate

endmodule

// ==== mux/mux_bin_tree.sv ====
// recursive mux tree, one select digit per level, instantiated by mux_bin with a padded width
`timescale 1ns/1ps

module mux_bin_tree #(
    parameter  type         DAT_T     = logic [8-1:0],
    // must be a power of SPLIT
    parameter  int unsigned WIDTH     = 16,
    parameter  int unsigned SPLIT     = 2,
    localparam int unsigned WIDTH_LOG = $clog2(WIDTH),
    localparam int unsigned SPLIT_LOG = $clog2(SPLIT)
)(
    input  logic [WIDTH_LOG-1:0] bin,
    input  DAT_T                 ary [WIDTH-1:0],
    output DAT_T                 dat
);

    generate
    if (WIDTH == SPLIT) begin: leaf

        // last level, plain indexed pick
        assign dat = ary[bin];

    end: leaf
    else begin: node

        // sub-tree width and its select width
        localparam int unsigned SUB     = WIDTH/SPLIT;
        localparam int unsigned SUB_LOG = WIDTH_LOG - SPLIT_LOG;

        DAT_T sub_dat [SPLIT-1:0];

        for (genvar s = 0; s < SPLIT; s++) begin: branch
            DAT_T sub_ary [SUB-1:0];

            // contiguous slice s of the input array
            always_comb begin
                for (int unsigned i = 0; i < SUB; i++) begin
                    sub_ary[i] = ary[s*SUB + i];
                end
            end

            // low digits select within the slice
            mux_bin_tree #(
                .DAT_T (DAT_T),
                .WIDTH (SUB),
                .SPLIT (SPLIT)
            ) i_sub (
                .bin (bin[SUB_LOG-1:0]),
                .ary (sub_ary),
                .dat (sub_dat[s])
            );
        end: branch

        // top digit selects among the slices
        assign dat = sub_dat[bin[WIDTH_LOG-1 -: SPLIT_LOG]];

    end: node
    endgenerate

endmodule

// ==== sim/byte_xbar_golden.txt ====
# W addr data bresp   (write, all hex, bresp 0 OKAY 2 SLVERR)
# R addr rresp rdata  (read, all hex)
# after reset, lanes unconfigured and sources zero
R 80 2 00000000
R 84 2 00000000
R 88 2 00000000
R 8c 2 00000000
R 00 0 00000000
# source bytes 0 to 11
W 00 000000a5 0
W 04 0000003c 0
W 08 00000071 0
W 0c 0000000e 0
W 10 000000c2 0
W 14 0000005b 0
W 18 00000099 0
W 1c 000000e4 0
W 20 00000027 0
W 24 000000d8 0
W 28 0000004f 0
W 2c 000000b6 0
# lane selects 0 5 11 7
W 40 00000000 0
W 44 00000005 0
W 48 0000000b 0
W 4c 00000007 0
R 80 0 000000a5
R 84 0 0000005b
R 88 0 000000b6
R 8c 0 000000e4
R 48 0 0000000b
# out of range selects keep the old byte
W 44 0000000c 2
W 4c 0000000f 2
R 84 0 0000005b
R 8c 0 000000e4
R 44 0 00000005
# rewrite source 11, only lane 2 follows
W 2c 0000001d 0
R 88 0 0000001d
R 80 0 000000a5
R 84 0 0000005b
R 8c 0 000000e4
# unmapped and read only addresses
W 30 00000011 2
W 80 00000022 2
W f0 00000033 2
R 30 2 00000000
R 50 2 00000000
R fc 2 00000000

// ==== sim/tb_byte_xbar.sv ====
// testbench that replays the golden transaction file over AXI4-Lite against the byte crossbar
`timescale 1ns/1ps
`include "xbar_macros.svh"

module tb_byte_xbar;

    logic                    clk;
    logic                    arst_n;
    logic [`XBAR_ADDR_W-1:0] awaddr;
    logic                    awvalid;
    logic                    awready;
    logic [31:0]             wdata;
    logic [3:0]              wstrb;
    logic                    wvalid;
    logic                    wready;
    logic [1:0]              bresp;
    logic                    bvalid;
    logic                    bready;
    logic [`XBAR_ADDR_W-1:0] araddr;
    logic                    arvalid;
    logic                    arready;
    logic [31:0]             rdata;
    logic [1:0]              rresp;
    logic                    rvalid;
    logic                    rready;

    // back-pressure source
    integer seed;
    int     errors;
    int     checks;
    int     cycles;
    int     cycle_limit;

    // golden transactions in file order
    byte                     kind_q [$];
    logic [`XBAR_ADDR_W-1:0] addr_q [$];
    logic [31:0]             data_q [$];
    logic [1:0]              resp_q [$];

    tb_clock #(.PERIOD(100)) i_clock (.clk(clk));

    byte_xbar_top i_byte_xbar_top (
        .clk     (clk),
        .arst_n  (arst_n),
        .awaddr  (awaddr),
        .awvalid (awvalid),
        .awready (awready),
        .wdata   (wdata),
        .wstrb   (wstrb),
        .wvalid  (wvalid),
        .wready  (wready),
        .bresp   (bresp),
        .bvalid  (bvalid),
        .bready  (bready),
        .araddr  (araddr),
        .arvalid (arvalid),
        .arready (arready),
        .rdata   (rdata),
        .rresp   (rresp),
        .rvalid  (rvalid),
        .rready  (rready)
    );

    ////////////////////////////////////////////////////////////
    // watchdog
    ////////////////////////////////////////////////////////////

    // limit stays zero until the golden file is loaded
    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycle_limit != 0 && cycles >= cycle_limit) begin
            $display("timeout, run did not finish within %0d cycles", cycle_limit);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////
    // golden file and bus tasks
    ////////////////////////////////////////////////////////////

    // W lines carry address, data, bresp; R lines carry address, rresp, rdata
    task automatic load_golden(output bit ok);
        int                      fd;
        int                      n;
        string                   line;
        byte                     kind;
        logic [`XBAR_ADDR_W-1:0] a;
        logic [31:0]             c2;
        logic [31:0]             c3;
        fd = $fopen("sim/byte_xbar_golden.txt", "r");
        ok = (fd != 0);
        if (ok) begin
            while (!$feof(fd)) begin
                line = "";
                n    = $fgets(line, fd);
                kind = line.getc(0);
                if (n > 0 && (kind == "W" || kind == "R")) begin
                    n = $sscanf(line.substr(2, line.len() - 1), "%h %h %h", a, c2, c3);
                    if (n != 3) begin
                        errors++;
                        $display("malformed golden line: %s", line);
                    end
                    kind_q.push_back(kind);
                    addr_q.push_back(a);
                    data_q.push_back(kind == "W" ? c2 : c3);
                    resp_q.push_back(kind == "W" ? c3[1:0] : c2[1:0]);
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic drive_write(input logic [`XBAR_ADDR_W-1:0] addr, input logic [31:0] data,
                               input logic [1:0] exp_resp);
        int delay;
        @(posedge clk);
        awaddr  <= addr;
        wdata   <= data;
        wstrb   <= 4'hf;
        awvalid <= 1'b1;
        wvalid  <= 1'b1;
        // AW and W are accepted on the same edge
        @(negedge clk);
        while (!(awready && wready)) @(negedge clk);
        @(posedge clk);
        awvalid <= 1'b0;
        wvalid  <= 1'b0;
        @(negedge clk);
        while (!bvalid) @(negedge clk);
        // bready held low a few cycles while the response waits
        delay = $unsigned($random(seed)) % 4;
        repeat (delay) @(negedge clk);
        @(posedge clk);
        bready <= 1'b1;
        @(negedge clk);
        checks++;
        if (!bvalid) begin
            errors++;
            $display("write response at %h dropped before bready", addr);
        end
        checks++;
        if (bresp !== exp_resp) begin
            errors++;
            $display("mismatch bresp at %h: expected %h, got %h", addr, exp_resp, bresp);
        end
        @(posedge clk);
        bready <= 1'b0;
        @(negedge clk);
        checks++;
        if (bvalid) begin
            errors++;
            $display("write response at %h delivered more than once", addr);
        end
    endtask

    task automatic drive_read(input logic [`XBAR_ADDR_W-1:0] addr, input logic [1:0] exp_resp,
                              input logic [31:0] exp_data);
        int delay;
        @(posedge clk);
        araddr  <= addr;
        arvalid <= 1'b1;
        @(negedge clk);
        while (!arready) @(negedge clk);
        @(posedge clk);
        arvalid <= 1'b0;
        @(negedge clk);
        while (!rvalid) @(negedge clk);
        // rready held low a few cycles while the response waits
        delay = $unsigned($random(seed)) % 4;
        repeat (delay) @(negedge clk);
        @(posedge clk);
        rready <= 1'b1;
        @(negedge clk);
        checks++;
        if (!rvalid) begin
            errors++;
            $display("read response at %h dropped before rready", addr);
        end
        checks++;
        if (rresp !== exp_resp) begin
            errors++;
            $display("mismatch rresp at %h: expected %h, got %h", addr, exp_resp, rresp);
        end
        checks++;
        if (rdata !== exp_data) begin
            errors++;
            $display("mismatch rdata at %h: expected %h, got %h", addr, exp_data, rdata);
        end
        @(posedge clk);
        rready <= 1'b0;
        @(negedge clk);
        checks++;
        if (rvalid) begin
            errors++;
            $display("read response at %h delivered more than once", addr);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////////////////////////

    initial begin
        bit ok;
        seed        = 32'h655e_30a6;
        errors      = 0;
        checks      = 0;
        cycles      = 0;
        cycle_limit = 0;
        arst_n      = 1'b0;
        awaddr      = '0;
        awvalid     = 1'b0;
        wdata       = '0;
        wstrb       = '0;
        wvalid      = 1'b0;
        bready      = 1'b0;
        araddr      = '0;
        arvalid     = 1'b0;
        rready      = 1'b0;
        load_golden(ok);
        if (!ok) begin
            $display("cannot open golden file sim/byte_xbar_golden.txt");
            $display("CHECKS FAILED");
            $finish;
        end else begin
            if (kind_q.size() == 0) begin
                errors++;
                $display("golden file holds no transactions");
            end
            cycle_limit = 40 * kind_q.size() + 20;
            // reset held over three rising edges
            repeat (3) @(posedge clk);
            arst_n <= 1'b1;
            foreach (kind_q[i]) begin
                if (kind_q[i] == "W") begin
                    drive_write(addr_q[i], data_q[i], resp_q[i]);
                end else begin
                    drive_read(addr_q[i], resp_q[i], data_q[i]);
                end
            end
            repeat (2) @(posedge clk);
            $display("%0d transactions, %0d checks, %0d errors", kind_q.size(), checks, errors);
            if (errors == 0) begin
                $display("ALL CHECKS PASSED");
            end else begin
                $display("CHECKS FAILED");
            end
            $finish;
        end
    end

endmodule

// ==== sim/tb_clock.sv ====
// testbench clock source, free running clock with a parameterized period in ns
`timescale 1ns/1ps

module tb_clock #(
    parameter int PERIOD = 100
)(
    output logic clk
);

    // start low, toggle every half period
    initial begin
        clk = 1'b0;
    end

    always begin
        #(PERIOD/2) clk = ~clk;
    end

endmodule
